// File: hw/kvs_pkg.sv
`default_nettype none

package kvs_pkg;

	// ------------------------------------------------------------------
	//   widths
	// ------------------------------------------------------------------
	localparam int KEY_BITS   = 96;
	localparam int VALUE_BITS = 32;
	localparam int HASH_FULL  = 32;
	localparam int SLOTS      = 4;

	typedef logic [1:0] slot_idx_t;

	// one slot of a bucket
	typedef struct packed {
		logic                  used;
		logic [KEY_BITS-1:0]   key;
		logic [VALUE_BITS-1:0] value;
	} kv_slot_t;

	// slot 0 sits in the lowest bits
	typedef kv_slot_t [SLOTS-1:0] bucket_t;

	// ------------------------------------------------------------------
	//   client requests and results
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [HASH_FULL-1:0]  hash;
		logic [KEY_BITS-1:0]   key;
		logic [VALUE_BITS-1:0] value;
	} set_req_t;

	typedef struct packed {
		logic [HASH_FULL-1:0] hash;
		logic [KEY_BITS-1:0]  key;
	} get_req_t;

	typedef struct packed {
		logic                  hit;
		logic [VALUE_BITS-1:0] value;
	} get_result_t;

endpackage

`default_nettype wire

// File: hw/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
	parameter int QUEUE_DEPTH = 4,
	parameter type payload_t = logic [7:0]
) (
	input  wire logic     ui_mig_clk,
	input  wire logic     ui_mig_rst,
	input  wire logic     push,
	input  wire payload_t push_data,
	input  wire logic     pop,
	output logic          not_empty,
	output payload_t      head,
	output logic          credit
);

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	payload_t mem [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                full;
	logic                do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign not_empty = (count != '0);
	assign full      = (count == CNT_BITS'(QUEUE_DEPTH));
	assign head      = mem[rd_ptr];
	assign do_pop    = pop & not_empty;

	// ------------------------------------------------------------------
	//   pointers and occupancy
	// ------------------------------------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per entry taken out
			credit <= do_pop;
		end
	end

	// entry storage
	always_ff @(posedge ui_mig_clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// client must hold a credit for every push
	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst) !(push && full))
		else $error("req_queue pushed while full, credit rule broken");

	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst) !(pop && !not_empty))
		else $error("req_queue popped while empty");

endmodule

`default_nettype wire

// File: hw/cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter import kvs_pkg::*; #(
	parameter int HASH_BITS = 6
) (
	input  wire logic                ui_mig_clk,
	input  wire logic                ui_mig_rst,
	input  wire logic                set_ready,
	input  wire set_req_t            set_head,
	input  wire logic                get_ready,
	input  wire get_req_t            get_head,
	output logic                     set_pop,
	output logic                     get_pop,
	output logic                     rd_en,
	output logic [HASH_BITS-1:0]     rd_index,
	output logic                     wr_en,
	output logic [HASH_BITS-1:0]     wr_index,
	output slot_idx_t                wr_slot,
	output kv_slot_t                 wr_data,
	output logic                     lookup_valid,
	output logic [KEY_BITS-1:0]      lookup_key
);

	logic       prefer_wr;
	logic       both_ready;
	logic       issue_set;
	logic       issue_get;
	logic [6:0] lfsr;

	// ------------------------------------------------------------------
	//   round robin between read and write queues
	// ------------------------------------------------------------------
	assign both_ready = set_ready & get_ready;
	assign issue_set  = set_ready & (~get_ready | prefer_wr);
	assign issue_get  = get_ready & (~set_ready | ~prefer_wr);

	// flips only on contested cycles, read side first after reset
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			prefer_wr <= 1'b0;
		else if (both_ready)
			prefer_wr <= ~prefer_wr;
	end

	assign set_pop = issue_set;
	assign get_pop = issue_get;

	// ------------------------------------------------------------------
	//   replacement slot
	// ------------------------------------------------------------------
	// x^7 + x^6 + 1, steps once per issued SET
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			lfsr <= 7'd1;
		else if (issue_set)
			lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
	end

	// ------------------------------------------------------------------
	//   store commands
	// ------------------------------------------------------------------
	assign rd_en    = issue_get;
	assign rd_index = get_head.hash[HASH_BITS-1:0];

	assign wr_en         = issue_set;
	assign wr_index      = set_head.hash[HASH_BITS-1:0];
	assign wr_slot       = lfsr[1:0];
	assign wr_data.used  = 1'b1;
	assign wr_data.key   = set_head.key;
	assign wr_data.value = set_head.value;

	// key rides along so it lines up with the bucket read data
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			lookup_valid <= 1'b0;
		else
			lookup_valid <= issue_get;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (issue_get)
			lookup_key <= get_head.key;
	end

	// a head that loses arbitration must wait unchanged for its pop
	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		set_ready && !set_pop |=> set_ready && $stable(set_head))
		else $error("cmd_arbiter saw the SET head change before its pop");

	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		get_ready && !get_pop |=> get_ready && $stable(get_head))
		else $error("cmd_arbiter saw the GET head change before its pop");

endmodule

`default_nettype wire

// File: hw/bucket_store.sv
`timescale 1ns/1ps
`default_nettype none

module bucket_store import kvs_pkg::*; #(
	parameter int HASH_BITS = 6
) (
	input  wire logic                 ui_mig_clk,
	input  wire logic                 ui_mig_rst,
	input  wire logic                 rd_en,
	input  wire logic [HASH_BITS-1:0] rd_index,
	output bucket_t                   rd_data,
	input  wire logic                 wr_en,
	input  wire logic [HASH_BITS-1:0] wr_index,
	input  wire slot_idx_t            wr_slot,
	input  wire kv_slot_t             wr_data
);

	localparam int BUCKETS = 2 ** HASH_BITS;

	logic [SLOTS-1:0]      used_mem  [BUCKETS];
	logic [KEY_BITS-1:0]   key_mem   [BUCKETS][SLOTS];
	logic [VALUE_BITS-1:0] value_mem [BUCKETS][SLOTS];

	// ------------------------------------------------------------------
	//   occupancy bits, cleared on reset
	// ------------------------------------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			for (int b = 0; b < BUCKETS; b++)
				used_mem[b] <= '0;
		end else if (wr_en) begin
			used_mem[wr_index][wr_slot] <= wr_data.used;
		end
	end

	// ------------------------------------------------------------------
	//   key and value storage, registered bucket read
	// ------------------------------------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (wr_en) begin
			key_mem[wr_index][wr_slot]   <= wr_data.key;
			value_mem[wr_index][wr_slot] <= wr_data.value;
		end
		if (rd_en) begin
			for (int s = 0; s < SLOTS; s++) begin
				rd_data[s].used  <= used_mem[rd_index][s];
				rd_data[s].key   <= key_mem[rd_index][s];
				rd_data[s].value <= value_mem[rd_index][s];
			end
		end
	end

	// the arbiter issues one command per cycle
	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst) !(rd_en && wr_en))
		else $error("bucket_store saw read and write in the same cycle");

endmodule

`default_nettype wire

// File: hw/lookup_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_pipe import kvs_pkg::*; (
	input  wire logic                ui_mig_clk,
	input  wire logic                ui_mig_rst,
	input  wire logic                lookup_valid,
	input  wire logic [KEY_BITS-1:0] lookup_key,
	input  wire bucket_t             rd_data,
	output logic                     out_valid,
	output get_result_t              result
);

	logic [SLOTS-1:0] match;
	get_result_t      result_d;

	// ------------------------------------------------------------------
	//   four-way compare
	// ------------------------------------------------------------------
	// empty slots never match, even on an all-zero key
	always_comb begin
		for (int s = 0; s < SLOTS; s++)
			match[s] = rd_data[s].used && (rd_data[s].key == lookup_key);
	end

	// lowest matching slot wins, so walk from the top down
	always_comb begin
		result_d.hit   = 1'b0;
		result_d.value = '0;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			if (match[s]) begin
				result_d.hit   = 1'b1;
				result_d.value = rd_data[s].value;
			end
		end
	end

	// ------------------------------------------------------------------
	//   result register
	// ------------------------------------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			out_valid <= 1'b0;
		else
			out_valid <= lookup_valid;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (lookup_valid)
			result <= result_d;
	end

endmodule

`default_nettype wire

// File: hw/kvs_top.sv
`timescale 1ns/1ps
`default_nettype none

module kvs_top import kvs_pkg::*; #(
	parameter int HASH_BITS   = 6,
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic     ui_mig_clk,
	input  wire logic     ui_mig_rst,
	input  wire logic     set_valid,
	input  wire set_req_t set_req,
	input  wire logic     get_valid,
	input  wire get_req_t get_req,
	output logic          set_credit,
	output logic          get_credit,
	output logic          out_valid,
	output get_result_t   result
);

	logic                 set_ready;
	logic                 get_ready;
	set_req_t             set_head;
	get_req_t             get_head;
	logic                 set_pop;
	logic                 get_pop;
	logic                 rd_en;
	logic [HASH_BITS-1:0] rd_index;
	bucket_t              rd_data;
	logic                 wr_en;
	logic [HASH_BITS-1:0] wr_index;
	slot_idx_t            wr_slot;
	kv_slot_t             wr_data;
	logic                 lookup_valid;
	logic [KEY_BITS-1:0]  lookup_key;

	// ------------------------------------------------------------------
	//   request queues
	// ------------------------------------------------------------------
	req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .payload_t(set_req_t)) u_set_queue (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.push(set_valid), .push_data(set_req),
		.pop(set_pop), .not_empty(set_ready), .head(set_head), .credit(set_credit)
	);

	req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .payload_t(get_req_t)) u_get_queue (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.push(get_valid), .push_data(get_req),
		.pop(get_pop), .not_empty(get_ready), .head(get_head), .credit(get_credit)
	);

	// ------------------------------------------------------------------
	//   command issue, storage and lookup
	// ------------------------------------------------------------------
	cmd_arbiter #(.HASH_BITS(HASH_BITS)) u_cmd_arbiter (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.set_ready(set_ready), .set_head(set_head),
		.get_ready(get_ready), .get_head(get_head),
		.set_pop(set_pop), .get_pop(get_pop),
		.rd_en(rd_en), .rd_index(rd_index),
		.wr_en(wr_en), .wr_index(wr_index), .wr_slot(wr_slot), .wr_data(wr_data),
		.lookup_valid(lookup_valid), .lookup_key(lookup_key)
	);

	bucket_store #(.HASH_BITS(HASH_BITS)) u_bucket_store (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data),
		.wr_en(wr_en), .wr_index(wr_index), .wr_slot(wr_slot), .wr_data(wr_data)
	);

	lookup_pipe u_lookup_pipe (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.lookup_valid(lookup_valid), .lookup_key(lookup_key), .rd_data(rd_data),
		.out_valid(out_valid), .result(result)
	);

endmodule

`default_nettype wire

// File: tests/kvs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module kvs_tb import kvs_pkg::*; ;

	localparam int HASH_BITS    = 6;
	localparam int QUEUE_DEPTH  = 4;
	localparam int BUCKETS      = 2 ** HASH_BITS;
	localparam int TABLE_LEN    = 13;
	localparam int STRESS_N     = 200;
	localparam int WATCH_CYCLES = (TABLE_LEN + STRESS_N) * 40;

	typedef struct {
		bit                    is_get;
		logic [31:0]           hash;
		logic [KEY_BITS-1:0]   key;
		logic [VALUE_BITS-1:0] value;
		bit                    exp_hit;
		logic [VALUE_BITS-1:0] exp_value;
	} entry_t;

	logic        ui_mig_clk;
	logic        ui_mig_rst;
	logic        set_valid;
	set_req_t    set_req;
	logic        get_valid;
	get_req_t    get_req;
	logic        set_credit;
	logic        get_credit;
	logic        out_valid;
	get_result_t result;

	entry_t      tbl [TABLE_LEN];
	kv_slot_t    ref_mem [BUCKETS][SLOTS];
	logic [6:0]  ref_lfsr;
	get_result_t exp_q [$];
	int          set_cred;
	int          get_cred;
	int          errors;
	int          checks;
	int          tests;
	logic [31:0] rng;

	kvs_top #(.HASH_BITS(HASH_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) dut (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.set_valid(set_valid), .set_req(set_req),
		.get_valid(get_valid), .get_req(get_req),
		.set_credit(set_credit), .get_credit(get_credit),
		.out_valid(out_valid), .result(result)
	);

	always #50 ui_mig_clk = ~ui_mig_clk;

	// ----------------------------------------------------------------------
	//   helpers
	// ----------------------------------------------------------------------
	task automatic check(input logic [127:0] actual, input logic [127:0] expected,
			input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t: %s, got %0h expected %0h", $time, msg, actual, expected);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic step();
		@(posedge ui_mig_clk);
		#1;
	endtask

	// reference store, slot picked by its own copy of the LFSR
	task automatic model_set(input set_req_t s);
		int b;
		b = int'(s.hash[HASH_BITS-1:0]);
		ref_mem[b][ref_lfsr[1:0]] = '{used: 1'b1, key: s.key, value: s.value};
		ref_lfsr = {ref_lfsr[5:0], ref_lfsr[6] ^ ref_lfsr[5]};
	endtask

	function automatic get_result_t model_get(input get_req_t g);
		get_result_t r;
		int          b;
		r = '0;
		b = int'(g.hash[HASH_BITS-1:0]);
		for (int s = SLOTS - 1; s >= 0; s--) begin
			if (ref_mem[b][s].used && ref_mem[b][s].key == g.key) begin
				r.hit   = 1'b1;
				r.value = ref_mem[b][s].value;
			end
		end
		return r;
	endfunction

	// drives one SET and/or one GET in the same cycle, under credit
	task automatic send_pair(input bit do_set, input set_req_t s,
			input bit do_get, input get_req_t g);
		while ((do_set && set_cred == 0) || (do_get && get_cred == 0))
			step();
		if (do_set) begin
			set_valid = 1'b1;
			set_req   = s;
			set_cred--;
		end
		if (do_get) begin
			get_valid = 1'b1;
			get_req   = g;
			get_cred--;
		end
		step();
		set_valid = 1'b0;
		get_valid = 1'b0;
	endtask

	// all credits home and no result outstanding
	task automatic drain();
		while (set_cred != QUEUE_DEPTH || get_cred != QUEUE_DEPTH || exp_q.size() != 0)
			step();
	endtask

	task automatic add_entry(input int i, input bit is_get, input logic [31:0] hash,
			input logic [KEY_BITS-1:0] key, input logic [VALUE_BITS-1:0] value,
			input bit exp_hit, input logic [VALUE_BITS-1:0] exp_value);
		tbl[i] = '{is_get, hash, key, value, exp_hit, exp_value};
	endtask

	// ----------------------------------------------------------------------
	//   result and credit monitor
	// ----------------------------------------------------------------------
	always @(posedge ui_mig_clk) begin
		if (!ui_mig_rst) begin
			if (set_credit === 1'b1) begin
				if (set_cred == QUEUE_DEPTH) begin
					errors++;
					$display("SET credit returned at %0t with no SET outstanding", $time);
				end else begin
					set_cred++;
				end
			end
			if (get_credit === 1'b1) begin
				if (get_cred == QUEUE_DEPTH) begin
					errors++;
					$display("GET credit returned at %0t with no GET outstanding", $time);
				end else begin
					get_cred++;
				end
			end
			if (out_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("result arrived at %0t with no GET outstanding", $time);
				end else begin
					check(128'(result.hit), 128'(exp_q[0].hit), "GET hit flag");
					check(128'(result.value), 128'(exp_q[0].value), "GET value");
					void'(exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge ui_mig_clk);
		$display("run timed out after %0d cycles, DUT stopped responding", WATCH_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	//   main sequence
	// ----------------------------------------------------------------------
	initial begin
		set_req_t    s;
		get_req_t    g;
		get_result_t m;
		int          e0;
		ui_mig_clk   = 1'b0;
		ui_mig_rst   = 1'b1;
		set_valid    = 1'b0;
		set_req      = '0;
		get_valid    = 1'b0;
		get_req      = '0;
		set_cred     = QUEUE_DEPTH;
		get_cred     = QUEUE_DEPTH;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		rng          = 32'h949a4f23;
		ref_lfsr     = 7'd1;
		for (int b = 0; b < BUCKETS; b++)
			for (int k = 0; k < SLOTS; k++)
				ref_mem[b][k] = '0;

		// hit and miss in bucket 3, then five keys into bucket 9
		// slots go 1, 2, 0, 0, 0, 0 so key 2 to 4 are overwritten
		add_entry(0, 0, 32'h0000_0003, 96'h0a0a, 32'h1111_0001, 0, 0);
		add_entry(1, 1, 32'h0000_0003, 96'h0a0a, 0, 1, 32'h1111_0001);
		add_entry(2, 1, 32'h0000_0003, 96'h0b0b, 0, 0, 0);
		for (int i = 0; i < 5; i++)
			add_entry(3 + i, 0, 32'hff00_0009, 96'(i + 1) << 64, 32'h2000 + i, 0, 0);
		add_entry(8, 1, 32'hff00_0009, 96'(1) << 64, 0, 1, 32'h2000);
		add_entry(9, 1, 32'hff00_0009, 96'(2) << 64, 0, 0, 0);
		add_entry(10, 1, 32'hff00_0009, 96'(3) << 64, 0, 0, 0);
		add_entry(11, 1, 32'hff00_0009, 96'(4) << 64, 0, 0, 0);
		add_entry(12, 1, 32'hff00_0009, 96'(5) << 64, 0, 1, 32'h2004);

		repeat (4) @(posedge ui_mig_clk);
		#1;
		ui_mig_rst = 1'b0;

		// reset: outputs stay quiet while idle
		e0 = errors;
		for (int i = 0; i < 5; i++) begin
			check(128'(out_valid), 0, "out_valid after reset");
			check(128'(set_credit), 0, "set_credit after reset");
			check(128'(get_credit), 0, "get_credit after reset");
			step();
		end
		tests++;
		$display("test reset: %0d errors", errors - e0);

		// table of hit, miss and replacement cases
		for (int i = 0; i < TABLE_LEN; i++) begin
			e0 = errors;
			if (tbl[i].is_get) begin
				g = '{hash: tbl[i].hash, key: tbl[i].key};
				m = model_get(g);
				check(128'(m.hit), 128'(tbl[i].exp_hit), "model hit against table");
				check(128'(m.value), 128'(tbl[i].exp_value), "model value against table");
				exp_q.push_back('{hit: tbl[i].exp_hit, value: tbl[i].exp_value});
				send_pair(0, '0, 1, g);
			end else begin
				s = '{hash: tbl[i].hash, key: tbl[i].key, value: tbl[i].value};
				model_set(s);
				send_pair(1, s, 0, '0);
			end
			drain();
			tests++;
			$display("test table %0d (%s): %0d errors", i, tbl[i].is_get ? "GET" : "SET",
				errors - e0);
		end

		// credits: four SETs and four GETs back to back
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			s = '{hash: 32'(20 + i), key: 96'h77_0000 + 96'(i), value: 32'h3000 + i};
			g = '{hash: (i < 2) ? 32'h3 : 32'hff00_0009,
				key: (i < 2) ? 96'h0a0a : 96'(i + 2) << 64};
			exp_q.push_back(model_get(g));
			model_set(s);
			send_pair(1, s, 1, g);
		end
		drain();
		for (int i = 0; i < 4; i++) begin
			g = '{hash: 32'(20 + i), key: 96'h77_0000 + 96'(i)};
			exp_q.push_back('{hit: 1'b1, value: 32'h3000 + i});
			send_pair(0, '0, 1, g);
		end
		drain();
		tests++;
		$display("test credits: %0d errors", errors - e0);

		// random stress, GET bucket differs from a SET in the same cycle
		e0 = errors;
		for (int i = 0; i < STRESS_N; i++) begin
			rng = xorshift(rng);
			s.hash = xorshift(rng);
			s.hash[5:3] = 3'b101;
			s.key = 96'h5000 + 96'(rng[11:8]);
			s.value = xorshift(s.hash);
			g.hash = (rng[1:0] == 2'd1) ? s.hash : (s.hash ^ 32'h1);
			g.key = 96'h5000 + 96'(rng[15:12]);
			if (rng[1:0] != 2'd0)
				exp_q.push_back(model_get(g));
			if (rng[1:0] != 2'd1)
				model_set(s);
			send_pair(rng[1:0] != 2'd1, s, rng[1:0] != 2'd0, g);
			drain();
		end
		tests++;
		$display("test stress: %0d ops, %0d errors", STRESS_N, errors - e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: kvs_top.f
hw/kvs_pkg.sv
hw/req_queue.sv
hw/cmd_arbiter.sv
hw/bucket_store.sv
hw/lookup_pipe.sv
hw/kvs_top.sv
tests/kvs_tb.sv

// File: Makefile
SIM_LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run kvs_tb, check the log for the pass line"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f kvs_top.f --top-module kvs_tb -o kvs_sim
	./obj_dir/kvs_sim | tee $(SIM_LOG)
	@grep -q "^TESTS PASSED$$" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
